// ==== common/sobel_macros.svh ====
`ifndef SOBEL_MACROS_SVH
`define SOBEL_MACROS_SVH

// Datapath widths
`define SOBEL_PIXEL_W 8
`define SOBEL_COL_W 8
`define SOBEL_WORD_W 32
`define SOBEL_GRAD_W 12
`define SOBEL_THRESH_W 16

// Longest supported camera line
`define SOBEL_LINE_DEPTH 256

// Custom-instruction register indexes, ciValueA[12:10]
`define SOBEL_REG_THRESHOLD 3'd4
`define SOBEL_REG_CONTROL 3'd5

// Output levels of one edge pixel
`define SOBEL_EDGE_ON 8'hFF
`define SOBEL_EDGE_OFF 8'h00

`endif

// ==== common/sobelPkg.sv ====
`include "sobel_macros.svh"

package sobelPkg;

    typedef logic [`SOBEL_PIXEL_W-1:0] pixelT;
    typedef logic [`SOBEL_COL_W-1:0] colIndexT;
    typedef logic [`SOBEL_WORD_W-1:0] wordT;
    typedef logic signed [`SOBEL_GRAD_W-1:0] gradT;
    typedef logic [`SOBEL_THRESH_W-1:0] thresholdT;

    // Byte 3*row+col, row 0 and col 0 are the oldest
    typedef logic [9*`SOBEL_PIXEL_W-1:0] windowT;

    // Rows seen since vsync
    typedef enum logic [1:0] {
        ROW_FIRST  = 2'd0,
        ROW_SECOND = 2'd1,
        ROW_STEADY = 2'd2
    } rowPhaseT;

endpackage

// ==== src/sobelConfigRegs.sv ====
`timescale 1ns/1ps
`include "sobel_macros.svh"

module sobelConfigRegs #(
    parameter logic [7:0] customId = 8'd0
) (
    input  logic               camClock,
    input  logic               rstN,
    input  logic               ciStart,
    input  logic [7:0]         ciN,
    input  sobelPkg::wordT     ciValueA,
    input  sobelPkg::wordT     ciValueB,
    output logic               ciDone,
    output sobelPkg::wordT     ciResult,
    output sobelPkg::thresholdT threshold,
    output logic               edgeEnable
);
    import sobelPkg::*;

    logic [2:0] regIndex;
    logic writeFlag;
    thresholdT thresholdReg;
    logic enableReg;

    assign ciDone = ciStart && (ciN == customId);
    assign regIndex = ciValueA[12:10];
    assign writeFlag = ciValueA[9];

    always_ff @(posedge camClock) begin
        if (!rstN) begin
            thresholdReg <= '0;
            enableReg <= 1'b0;
        end else if (ciDone && writeFlag) begin
            if (regIndex == `SOBEL_REG_THRESHOLD) begin
                thresholdReg <= ciValueB[`SOBEL_THRESH_W-1:0];
            end
            if (regIndex == `SOBEL_REG_CONTROL) begin
                enableReg <= ciValueB[0];
            end
        end
    end

    // Writes and foreign instructions return zero
    always_comb begin
        ciResult = '0;
        if (ciDone && !writeFlag) begin
            case (regIndex)
                `SOBEL_REG_THRESHOLD: ciResult = wordT'(thresholdReg);
                `SOBEL_REG_CONTROL: ciResult = wordT'(enableReg);
                default: ciResult = '0;
            endcase
        end
    end

    assign threshold = thresholdReg;
    assign edgeEnable = enableReg;

endmodule

// ==== src/scanTracker.sv ====
`timescale 1ns/1ps

module scanTracker (
    input  logic               camClock,
    input  logic               rstN,
    input  logic               validCamera,
    input  logic               hsync,
    input  logic               vsync,
    output sobelPkg::colIndexT column,
    output logic               windowValid
);
    import sobelPkg::*;

    colIndexT columnReg;
    rowPhaseT rowPhase;
    rowPhaseT nextPhase;

    always_ff @(posedge camClock) begin
        if (!rstN || hsync) begin
            columnReg <= '0;
        end else if (validCamera) begin
            columnReg <= columnReg + 1'b1;
        end
    end

    // vsync wins over a coincident hsync
    always_comb begin
        nextPhase = rowPhase;
        if (vsync) begin
            nextPhase = ROW_FIRST;
        end else if (hsync) begin
            case (rowPhase)
                ROW_FIRST: nextPhase = ROW_SECOND;
                ROW_SECOND: nextPhase = ROW_STEADY;
                default: nextPhase = ROW_STEADY;
            endcase
        end
    end

    always_ff @(posedge camClock) begin
        if (!rstN) begin
            rowPhase <= ROW_FIRST;
        end else begin
            rowPhase <= nextPhase;
        end
    end

    // Two earlier columns must already sit in the window
    assign windowValid = validCamera && (rowPhase == ROW_STEADY) && (columnReg >= colIndexT'(2));
    assign column = columnReg;

endmodule

// ==== filter/lineBufferWindow.sv ====
`timescale 1ns/1ps
`include "sobel_macros.svh"

module lineBufferWindow (
    input  logic               camClock,
    input  logic               validCamera,
    input  sobelPkg::pixelT    camData,
    input  sobelPkg::colIndexT column,
    output sobelPkg::windowT   window
);
    import sobelPkg::*;

    // Line two rows back and line one row back
    pixelT olderLine [`SOBEL_LINE_DEPTH];
    pixelT newerLine [`SOBEL_LINE_DEPTH];

    // Index 0 is the top row of the window
    pixelT leftCol [3];
    pixelT midCol [3];
    pixelT liveCol [3];

    assign liveCol[0] = olderLine[column];
    assign liveCol[1] = newerLine[column];
    assign liveCol[2] = camData;

    always_ff @(posedge camClock) begin
        if (validCamera) begin
            olderLine[column] <= newerLine[column];
            newerLine[column] <= camData;
        end
    end

    always_ff @(posedge camClock) begin
        if (validCamera) begin
            leftCol <= midCol;
            midCol <= liveCol;
        end
    end

    genvar r;
    generate
        for (r = 0; r < 3; r++) begin : gRow
            assign window[(3*r)*`SOBEL_PIXEL_W +: `SOBEL_PIXEL_W] = leftCol[r];
            assign window[(3*r+1)*`SOBEL_PIXEL_W +: `SOBEL_PIXEL_W] = midCol[r];
            assign window[(3*r+2)*`SOBEL_PIXEL_W +: `SOBEL_PIXEL_W] = liveCol[r];
        end
    endgenerate

endmodule

// ==== filter/sobelKernel.sv ====
`timescale 1ns/1ps
`include "sobel_macros.svh"

module sobelKernel (
    input  sobelPkg::windowT    window,
    input  sobelPkg::thresholdT threshold,
    output sobelPkg::pixelT     edgePixel
);
    import sobelPkg::*;

    function automatic gradT pixelAt(input windowT w, input int r, input int c);
        return gradT'(w[(3*r+c)*`SOBEL_PIXEL_W +: `SOBEL_PIXEL_W]);
    endfunction

    gradT gradX;
    gradT gradY;
    logic [`SOBEL_GRAD_W-1:0] absX;
    logic [`SOBEL_GRAD_W-1:0] absY;
    thresholdT magnitude;

    // Right column minus left column, weights 1 2 1
    assign gradX = (pixelAt(window, 0, 2) + (pixelAt(window, 1, 2) <<< 1) + pixelAt(window, 2, 2))
                 - (pixelAt(window, 0, 0) + (pixelAt(window, 1, 0) <<< 1) + pixelAt(window, 2, 0));

    // Bottom row minus top row
    assign gradY = (pixelAt(window, 2, 0) + (pixelAt(window, 2, 1) <<< 1) + pixelAt(window, 2, 2))
                 - (pixelAt(window, 0, 0) + (pixelAt(window, 0, 1) <<< 1) + pixelAt(window, 0, 2));

    // At most 1020 each, so negation cannot overflow
    assign absX = gradX[`SOBEL_GRAD_W-1] ? -gradX : gradX;
    assign absY = gradY[`SOBEL_GRAD_W-1] ? -gradY : gradY;

    assign magnitude = thresholdT'(absX) + thresholdT'(absY);
    assign edgePixel = (magnitude > threshold) ? `SOBEL_EDGE_ON : `SOBEL_EDGE_OFF;

endmodule

// ==== src/edgePacker.sv ====
`timescale 1ns/1ps
`include "sobel_macros.svh"

module edgePacker (
    input  logic            camClock,
    input  logic            rstN,
    input  logic            hsync,
    input  logic            windowValid,
    input  logic            edgeEnable,
    input  sobelPkg::pixelT edgePixel,
    output sobelPkg::wordT  edgeWord,
    output logic            wordValid
);
    import sobelPkg::*;

    logic [1:0] groupCount;
    logic [3*`SOBEL_PIXEL_W-1:0] pending;
    logic takePixel;

    assign takePixel = windowValid && edgeEnable;

    // Leftover pixels of a line are dropped
    always_ff @(posedge camClock) begin
        if (!rstN || hsync) begin
            groupCount <= 2'd0;
        end else if (takePixel) begin
            groupCount <= groupCount + 2'd1;
        end
    end

    always_ff @(posedge camClock) begin
        if (!rstN) begin
            wordValid <= 1'b0;
        end else begin
            wordValid <= takePixel && (groupCount == 2'd3);
        end
    end

    // First pixel ends up in the top byte
    always_ff @(posedge camClock) begin
        if (takePixel) begin
            pending <= {pending[2*`SOBEL_PIXEL_W-1:0], edgePixel};
            if (groupCount == 2'd3) begin
                edgeWord <= {pending, edgePixel};
            end
        end
    end

endmodule

// ==== src/sobelAccelerator.sv ====
`timescale 1ns/1ps

module sobelAccelerator #(
    parameter logic [7:0] customId = 8'd0
) (
    input  logic            camClock,
    input  logic            rstN,
    input  logic            hsync,
    input  logic            vsync,
    input  logic            validCamera,
    input  logic            ciStart,
    input  logic [7:0]      ciN,
    input  sobelPkg::pixelT camData,
    input  sobelPkg::wordT  ciValueA,
    input  sobelPkg::wordT  ciValueB,
    output logic            ciDone,
    output sobelPkg::wordT  ciResult,
    output sobelPkg::wordT  edgeWord,
    output logic            wordValid
);
    import sobelPkg::*;

    thresholdT threshold;
    logic edgeEnable;
    colIndexT column;
    logic windowValid;
    windowT window;
    pixelT edgePixel;

    sobelConfigRegs #(
        .customId(customId)
    ) u_sobelConfigRegs (
        .camClock  (camClock),
        .rstN      (rstN),
        .ciStart   (ciStart),
        .ciN       (ciN),
        .ciValueA  (ciValueA),
        .ciValueB  (ciValueB),
        .ciDone    (ciDone),
        .ciResult  (ciResult),
        .threshold (threshold),
        .edgeEnable(edgeEnable)
    );

    scanTracker u_scanTracker (
        .camClock   (camClock),
        .rstN       (rstN),
        .validCamera(validCamera),
        .hsync      (hsync),
        .vsync      (vsync),
        .column     (column),
        .windowValid(windowValid)
    );

    lineBufferWindow u_lineBufferWindow (
        .camClock   (camClock),
        .validCamera(validCamera),
        .camData    (camData),
        .column     (column),
        .window     (window)
    );

    sobelKernel u_sobelKernel (
        .window   (window),
        .threshold(threshold),
        .edgePixel(edgePixel)
    );

    edgePacker u_edgePacker (
        .camClock   (camClock),
        .rstN       (rstN),
        .hsync      (hsync),
        .windowValid(windowValid),
        .edgeEnable (edgeEnable),
        .edgePixel  (edgePixel),
        .edgeWord   (edgeWord),
        .wordValid  (wordValid)
    );

endmodule

// ==== tests/sobelAccelerator_assertions.sv ====
`timescale 1ns/1ps

module sobelAccelerator_assertions #(
    parameter logic [7:0] customId = 8'd0
) (
    input logic       camClock,
    input logic       rstN,
    input logic       windowValid,
    input logic       wordValid,
    input logic       ciDone,
    input logic [7:0] ciN
);

    // A word only follows an accepted window
    wordAfterWindow: assert property (@(posedge camClock) disable iff (!rstN)
        $rose(wordValid) |-> $past(windowValid))
        else $error("wordValid rose without windowValid in the previous cycle");

    // Four pixels per word keep the strobes apart
    wordPulseSpacing: assert property (@(posedge camClock) disable iff (!rstN)
        wordValid |-> !$past(wordValid, 1) && !$past(wordValid, 2) && !$past(wordValid, 3))
        else $error("wordValid pulsed again within three cycles");

    ciDoneOwnId: assert property (@(posedge camClock) disable iff (!rstN)
        ciDone |-> ciN == customId)
        else $error("ciDone high for an instruction with a foreign ciN");

endmodule

bind sobelAccelerator sobelAccelerator_assertions #(
    .customId(customId)
) u_sobelAccelerator_assertions (
    .camClock   (camClock),
    .rstN       (rstN),
    .windowValid(windowValid),
    .wordValid  (wordValid),
    .ciDone     (ciDone),
    .ciN        (ciN)
);

// ==== tests/sobelAccelerator_tb.sv ====
`timescale 1ns/1ps

module sobelAccelerator_tb;
    import sobelPkg::*;

    localparam logic [7:0] customId = 8'h2A;
    localparam int wordTimeout = 40;

    logic camClock = 1'b0;
    logic rstN = 1'b0;
    logic hsync = 1'b0;
    logic vsync = 1'b0;
    logic validCamera = 1'b0;
    logic ciStart = 1'b0;
    logic [7:0] ciN = 8'h00;
    pixelT camData = '0;
    wordT ciValueA = '0;
    wordT ciValueB = '0;
    logic ciDone;
    wordT ciResult;
    wordT edgeWord;
    logic wordValid;

    integer seed = 32'hfb8f;
    int valueErrors = 0;
    int otherErrors = 0;
    logic quietRows = 1'b0;
    wordT expectedQ [$];
    wordT rowWords [$];
    pixelT rowPixels [10];
    wordT expectedWord;

    always #50 camClock = ~camClock;

    sobelAccelerator #(.customId(customId)) u_sobelAccelerator (.*);

    // Outputs have settled by the falling edge
    always @(negedge camClock) begin
        if (rstN && wordValid) begin
            assert (!quietRows && expectedQ.size() > 0) else begin
                otherErrors++;
                $display("edge word strobed where none was expected");
            end
            if (expectedQ.size() > 0) begin
                expectedWord = expectedQ.pop_front();
                assert (edgeWord == expectedWord) else begin
                    valueErrors++;
                    $display("mismatch edgeWord: got %h, expected %h", edgeWord, expectedWord);
                end
            end
        end
    end

    task automatic issueInstruction(input logic [2:0] index, input logic write,
                                    input logic foreign, input wordT valueB,
                                    input wordT expected);
        @(posedge camClock);
        ciStart <= 1'b1;
        ciN <= foreign ? ~customId : customId;
        ciValueA <= {19'd0, index, write, 9'd0};
        ciValueB <= valueB;
        @(negedge camClock);
        assert (ciDone == !foreign) else begin
            valueErrors++;
            $display("mismatch ciDone: got %h, expected %h", ciDone, !foreign);
        end
        assert (ciResult == expected) else begin
            valueErrors++;
            $display("mismatch ciResult: got %h, expected %h", ciResult, expected);
        end
        @(posedge camClock);
        ciStart <= 1'b0;
    endtask

    // vsync, then every row of the current pattern followed by hsync
    task automatic runFrame(input int width, input int height);
        int gap;
        @(posedge camClock);
        vsync <= 1'b1;
        @(posedge camClock);
        vsync <= 1'b0;
        for (int row = 0; row < height; row++) begin
            quietRows = (row < 2);
            if (row >= 2) begin
                foreach (rowWords[i]) begin
                    expectedQ.push_back(rowWords[i]);
                end
            end
            for (int col = 0; col < width; col++) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) begin
                    @(posedge camClock);
                    validCamera <= 1'b0;
                end
                @(posedge camClock);
                validCamera <= 1'b1;
                camData <= rowPixels[col];
            end
            @(posedge camClock);
            validCamera <= 1'b0;
            hsync <= 1'b1;
            @(posedge camClock);
            hsync <= 1'b0;
        end
        quietRows = 1'b0;
    endtask

    task automatic waitForWords();
        int cycles;
        cycles = 0;
        while (expectedQ.size() > 0 && cycles < wordTimeout) begin
            @(negedge camClock);
            cycles++;
        end
        assert (expectedQ.size() == 0) else begin
            otherErrors++;
            $display("timed out with %0d edge words never strobed", expectedQ.size());
            expectedQ.delete();
        end
    endtask

    initial begin
        int fd;
        int fields;
        string line;
        wordT argA;
        wordT argB;
        repeat (3) @(posedge camClock);
        rstN <= 1'b1;
        fd = $fopen("tests/sobelTests.txt", "r");
        assert (fd != 0) else begin
            otherErrors++;
            $display("could not open tests/sobelTests.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            fields = $fgets(line, fd);
            if (fields > 1 && line[0] != "#") begin
                case (line[0])
                    "w": begin
                        fields = $sscanf(line, "w %h %h", argA, argB);
                        issueInstruction(argA[2:0], 1'b1, 1'b0, argB, '0);
                    end
                    "r": begin
                        fields = $sscanf(line, "r %h %h", argA, argB);
                        issueInstruction(argA[2:0], 1'b0, 1'b0, '0, argB);
                    end
                    "m": begin
                        fields = $sscanf(line, "m %h", argA);
                        issueInstruction(argA[2:0], 1'b0, 1'b1, '0, '0);
                    end
                    "p": fields = $sscanf(line, "p %h %h %h %h %h %h %h %h %h %h",
                                          rowPixels[0], rowPixels[1], rowPixels[2], rowPixels[3],
                                          rowPixels[4], rowPixels[5], rowPixels[6], rowPixels[7],
                                          rowPixels[8], rowPixels[9]);
                    "e": begin
                        fields = $sscanf(line, "e %h", argA);
                        rowWords.push_back(argA);
                    end
                    "f": begin
                        fields = $sscanf(line, "f %d %d", argA, argB);
                        runFrame(argA, argB);
                        waitForWords();
                        rowWords.delete();
                    end
                    default: begin
                        otherErrors++;
                        $display("unknown command in the test file");
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("Errors: %0d mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tests/sobelTests.txt ====
# op: w write (index, value), r read (index, expected), m foreign read (index), all hex
# op: p row pixels (ten hex), e word of each steady row (hex), f frame (width, height decimal)
w 4 00000064
w 5 00000001
r 4 00000064
r 5 00000001
r 1 00000000
m 4
p 00 00 00 00 00 c8 c8 c8 c8 c8
e 000000ff
e ff000000
f 10 6
w 4 000007f8
r 4 000007f8
e 00000000
e 00000000
f 10 6
w 5 00000000
r 5 00000000
f 10 6
w 4 00000064
w 5 00000001
e 000000ff
e ff000000
f 10 6

// ==== sobelAccelerator.f ====
+incdir+common
common/sobelPkg.sv
src/sobelConfigRegs.sv
src/scanTracker.sv
filter/lineBufferWindow.sv
filter/sobelKernel.sv
src/edgePacker.sv
src/sobelAccelerator.sv
tests/sobelAccelerator_assertions.sv
tests/sobelAccelerator_tb.sv

// ==== Makefile ====
TOP = sobelAccelerator_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f sobelAccelerator.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Test passed" > /dev/null

lint:
	verilator --lint-only --timing --assert -f sobelAccelerator.f --top-module $(TOP)

clean:
	rm -rf obj_dir
